// File: pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] u32_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        BYTE      = 2'd0,
        HALF_WORD = 2'd1,
        WORD      = 2'd2
    } byte_type_e;

    // record handed over by the execute stage
    typedef struct packed {
        logic       valid;
        logic       is_mem;
        logic       is_store;
        logic       is_signed;
        byte_type_e byte_type;
        u32_t       addr;
        u32_t       rkd_data;
        reg_idx_t   rd;
    } exe_mem1_pass_t;

    typedef enum logic [5:0] {
        ADEF = 6'h08,
        ALE  = 6'h09
    } excp_code_e;

    typedef struct packed {
        logic       valid;
        excp_code_e code;
        u32_t       badv;
    } excp_pass_t;

endpackage

// File: dmem_pkg.sv
package dmem_pkg;

    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LANE_W     = 2;
    localparam int WORD_IDX_W = 32 - LANE_W;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [LANE_W-1:0]     lane_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    typedef struct packed {
        logic                 is_store;
        logic                 is_signed;
        pipe_pkg::byte_type_e byte_type;
        word_idx_t            word_idx;
        lane_t                lane;
        strb_t                strb;
        data_t                wdata;
        pipe_pkg::reg_idx_t   rd;
    } dmem_req_t;

    typedef struct packed {
        logic               is_store;
        pipe_pkg::reg_idx_t rd;
        data_t              rdata;
    } dmem_resp_t;

endpackage

// File: mem1_stage.sv
`timescale 1ns/1ps

module mem1_stage #(
    parameter int BUF_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  pipe_pkg::exe_mem1_pass_t pass_i,
    output logic                     stall_o,
    output pipe_pkg::excp_pass_t     excp_o,
    output logic                     req_valid_o,
    output dmem_pkg::dmem_req_t      req_o,
    input  logic                     credit_i
);

    import pipe_pkg::*;
    import dmem_pkg::*;

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int IDX_W = $clog2(MEM_WORDS);

    logic           cur_valid;
    exe_mem1_pass_t pass_r;
    logic           live;
    logic           is_mem_op;
    logic           misaligned;
    logic           issue_want;
    logic           has_credit;
    logic           send;
    logic [CNT_W-1:0] credit_cnt;

    // a flush kills both the op held here and the one arriving from execute
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_valid <= 1'b0;
        end else if (flush_i) begin
            cur_valid <= 1'b0;
        end else if (!stall_o) begin
            cur_valid <= pass_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            pass_r <= pass_i;
        end
    end

    assign live      = cur_valid & ~flush_i;
    assign is_mem_op = live & pass_r.is_mem;

    always_comb begin
        case (pass_r.byte_type)
            HALF_WORD: misaligned = pass_r.addr[0];
            WORD:      misaligned = |pass_r.addr[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    assign issue_want  = is_mem_op & ~misaligned;
    assign has_credit  = (credit_cnt != '0);
    assign stall_o     = issue_want & ~has_credit;
    assign send        = issue_want & has_credit;
    assign req_valid_o = send;

    always_comb begin
        excp_o.valid = is_mem_op & misaligned;
        excp_o.code  = ALE;
        excp_o.badv  = pass_r.addr;
    end

    // one credit per free buffer entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= CNT_W'(BUF_DEPTH);
        end else if (send && !credit_i) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!send && credit_i) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_comb begin
        req_o           = '0;
        req_o.is_store  = pass_r.is_store;
        req_o.is_signed = pass_r.is_signed;
        req_o.byte_type = pass_r.byte_type;
        req_o.word_idx[IDX_W-1:0] = pass_r.addr[LANE_W +: IDX_W];
        req_o.lane      = pass_r.addr[LANE_W-1:0];
        req_o.rd        = pass_r.rd;

        // store data is copied into every lane, the strobe picks the live bytes
        case (pass_r.byte_type)
            BYTE: begin
                req_o.wdata = {4{pass_r.rkd_data[7:0]}};
                req_o.strb  = strb_t'(1) << pass_r.addr[1:0];
            end
            HALF_WORD: begin
                req_o.wdata = {2{pass_r.rkd_data[15:0]}};
                req_o.strb  = pass_r.addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                req_o.wdata = pass_r.rkd_data;
                req_o.strb  = 4'b1111;
            end
        endcase

        if (!pass_r.is_store) begin
            req_o.strb = '0;
        end
    end

endmodule

// File: dmem_req_buffer.sv
`timescale 1ns/1ps

module dmem_req_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push_i,
    input  dmem_pkg::dmem_req_t push_data_i,
    output logic                pop_valid_o,
    output dmem_pkg::dmem_req_t pop_data_o,
    input  logic                pop_ready_i,
    output logic                credit_o
);

    import dmem_pkg::*;

    localparam int PTR_W = $clog2(BUF_DEPTH);
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    dmem_req_t        entries [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign pop_valid_o = (count != '0);
    assign pop_data_o  = entries[rd_ptr];
    assign pop         = pop_valid_o & pop_ready_i;
    // every pop frees one slot, which goes back to the sender as a credit
    assign credit_o    = pop;

    always_ff @(posedge clk) begin
        if (push_i) begin
            entries[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_i && !pop) begin
                count <= count + 1'b1;
            end else if (!push_i && pop) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: dmem_unit.sv
`timescale 1ns/1ps

module dmem_unit #(
    parameter int MEM_WORDS = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid_i,
    input  dmem_pkg::dmem_req_t  req_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output dmem_pkg::dmem_resp_t resp_o,
    input  logic                 resp_ready_i
);

    import pipe_pkg::*;
    import dmem_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    data_t            mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             accept;
    data_t            rd_word;
    data_t            shifted;
    data_t            load_data;
    dmem_resp_t       next_resp;

    // take a new request only when the output register is free or drains now
    assign req_ready_o = ~resp_valid_o | resp_ready_i;
    assign accept      = req_valid_i & req_ready_o;
    assign idx         = req_i.word_idx[IDX_W-1:0];
    assign rd_word     = mem[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && req_i.is_store) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (req_i.strb[b]) begin
                    mem[idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        shifted = rd_word >> {req_i.lane, 3'b000};
        case (req_i.byte_type)
            BYTE:      load_data = {{24{req_i.is_signed & shifted[7]}}, shifted[7:0]};
            HALF_WORD: load_data = {{16{req_i.is_signed & shifted[15]}}, shifted[15:0]};
            default:   load_data = shifted;
        endcase
    end

    always_comb begin
        next_resp.is_store = req_i.is_store;
        next_resp.rd       = req_i.rd;
        next_resp.rdata    = req_i.is_store ? '0 : load_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_o <= 1'b0;
        end else if (accept) begin
            resp_valid_o <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_o <= next_resp;
        end
    end

endmodule

// File: mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int BUF_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  pipe_pkg::exe_mem1_pass_t pass_i,
    output logic                     stall_o,
    output pipe_pkg::excp_pass_t     excp_o,
    output logic                     resp_valid_o,
    output dmem_pkg::dmem_resp_t     resp_o,
    input  logic                     resp_ready_i
);

    import dmem_pkg::*;

    logic      req_valid;
    dmem_req_t req;
    logic      credit_return;
    logic      pop_valid;
    logic      pop_ready;
    dmem_req_t pop_data;

    mem1_stage #(
        .BUF_DEPTH (BUF_DEPTH),
        .MEM_WORDS (MEM_WORDS)
    ) i_mem1_stage (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .pass_i      (pass_i),
        .stall_o     (stall_o),
        .excp_o      (excp_o),
        .req_valid_o (req_valid),
        .req_o       (req),
        .credit_i    (credit_return)
    );

    // the buffer has no ready, the stage's credits keep it from overflowing
    dmem_req_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_dmem_req_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (req_valid),
        .push_data_i (req),
        .pop_valid_o (pop_valid),
        .pop_data_o  (pop_data),
        .pop_ready_i (pop_ready),
        .credit_o    (credit_return)
    );

    dmem_unit #(
        .MEM_WORDS (MEM_WORDS)
    ) i_dmem_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (pop_valid),
        .req_i        (pop_data),
        .req_ready_o  (pop_ready),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i)
    );

endmodule

// File: mem_subsys_props.sv
`timescale 1ns/1ps

module mem_subsys_props #(
    parameter int BUF_DEPTH = 4
) (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             push_i,
    input logic                             pop_valid_i,
    input logic                             pop_ready_i,
    input dmem_pkg::dmem_req_t              pop_data_i,
    input logic [$clog2(BUF_DEPTH + 1)-1:0] count_i
);

    localparam int CNT_W = $clog2(BUF_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(BUF_DEPTH);

    int fail_count = 0;

    // the sender's credits must keep it away from a full FIFO
    push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> count_i != FULL)
        else begin
            $error("push into a full request FIFO");
            fail_count++;
        end

    count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        count_i <= FULL)
        else begin
            $error("request FIFO occupancy above its depth");
            fail_count++;
        end

    // the head entry may not change while the memory unit holds it off
    head_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pop_valid_i && !pop_ready_i |=> pop_valid_i && $stable(pop_data_i))
        else begin
            $error("request FIFO head changed while waiting for pop_ready");
            fail_count++;
        end

endmodule

bind dmem_req_buffer mem_subsys_props #(
    .BUF_DEPTH (BUF_DEPTH)
) i_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push_i),
    .pop_valid_i (pop_valid_o),
    .pop_ready_i (pop_ready_i),
    .pop_data_i  (pop_data_o),
    .count_i     (count)
);

// File: mem_subsys_checker.sv
`timescale 1ns/1ps

module mem_subsys_checker #(
    parameter int BUF_DEPTH = 4,
    parameter int MEM_WORDS = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush_i,
    input  pipe_pkg::exe_mem1_pass_t pass_i,
    input  logic                     stall_i,
    input  pipe_pkg::excp_pass_t     excp_i,
    input  logic                     resp_valid_i,
    input  dmem_pkg::dmem_resp_t     resp_i,
    input  logic                     resp_ready_i,
    output int                       error_count_o,
    output int                       pending_o,
    output int                       resp_count_o
);

    import pipe_pkg::*;
    import dmem_pkg::*;

    localparam int MEM_BYTES = MEM_WORDS * 4;

    logic [7:0]     ref_mem [MEM_BYTES];
    dmem_resp_t     exp_q [$];
    logic           held_valid = 1'b0;
    exe_mem1_pass_t held_op;
    int             errors = 0;
    int             pushed = 0;
    int             responses = 0;
    int             credits = 0;

    assign error_count_o = errors;
    assign resp_count_o  = responses;
    assign pending_o     = pushed - responses + (held_valid ? 1 : 0);

    function automatic logic is_misaligned(input exe_mem1_pass_t op);
        if (op.byte_type == HALF_WORD) begin
            return op.addr[0];
        end
        return (op.byte_type == WORD) && (op.addr[1:0] != 2'b00);
    endfunction

    // little-endian byte model, a store answers with zero data
    function automatic dmem_resp_t ref_access(input exe_mem1_pass_t op);
        dmem_resp_t  r;
        int          base;
        int          nbytes;
        logic [31:0] val;
        base   = int'(op.addr % MEM_BYTES);
        nbytes = (op.byte_type == BYTE) ? 1 : (op.byte_type == HALF_WORD) ? 2 : 4;
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (op.is_store) begin
                ref_mem[base + i] = op.rkd_data[8*i +: 8];
            end else begin
                val[8*i +: 8] = ref_mem[base + i];
            end
        end
        if (!op.is_store && op.is_signed && val[8*nbytes-1]) begin
            for (int i = 8 * nbytes; i < 32; i++) begin
                val[i] = 1'b1;
            end
        end
        r.is_store = op.is_store;
        r.rd       = op.rd;
        r.rdata    = val;
        return r;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        exp_q.delete();
        held_valid = 1'b0;
        held_op    = '0;
    endtask

    task automatic compare_response();
        dmem_resp_t exp_r;
        if (resp_valid_i && resp_ready_i) begin
            responses++;
            if (exp_q.size() == 0) begin
                $display("response at %0t arrived with no operation left to answer", $time);
                errors++;
            end else begin
                exp_r = exp_q.pop_front();
                if (resp_i.is_store !== exp_r.is_store) begin
                    $display("error: resp_o.is_store got %h expected %h", resp_i.is_store,
                             exp_r.is_store);
                    errors++;
                end
                if (resp_i.rd !== exp_r.rd) begin
                    $display("error: resp_o.rd got %h expected %h", resp_i.rd, exp_r.rd);
                    errors++;
                end
                if (resp_i.rdata !== exp_r.rdata) begin
                    $display("error: resp_o.rdata got %h expected %h", resp_i.rdata,
                             exp_r.rdata);
                    errors++;
                end
            end
        end
    endtask

    // mirrors the stage register, an op leaves it on a cycle without stall or flush
    task automatic follow_stage();
        logic exp_excp;
        logic exp_stall;
        logic waiting;
        exp_excp  = 1'b0;
        waiting   = held_valid && !flush_i && held_op.is_mem && !is_misaligned(held_op);
        exp_stall = waiting && (credits == 0);
        if (stall_i !== exp_stall) begin
            $display("error: stall_o got %h expected %h", stall_i, exp_stall);
            errors++;
        end
        if (held_valid && !flush_i && !stall_i && held_op.is_mem) begin
            if (is_misaligned(held_op)) begin
                exp_excp = 1'b1;
            end else begin
                exp_q.push_back(ref_access(held_op));
                pushed++;
            end
        end
        if (excp_i.valid !== exp_excp) begin
            $display("error: excp_o.valid got %h expected %h", excp_i.valid, exp_excp);
            errors++;
        end else if (exp_excp && (excp_i.code !== ALE || excp_i.badv !== held_op.addr)) begin
            $display("error: excp_o.code/badv got %h/%h expected %h/%h", excp_i.code,
                     excp_i.badv, ALE, held_op.addr);
            errors++;
        end
        if (flush_i) begin
            held_valid = 1'b0;
        end else if (!stall_i) begin
            held_valid = pass_i.valid;
            held_op    = pass_i;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n !== 1'b1) begin
            reset_model();
        end else begin
            // a credit comes back on the pop, and a popped entry sits in the
            // memory unit's output register until it is accepted
            credits = BUF_DEPTH - pushed + responses + (resp_valid_i ? 1 : 0);
            compare_response();
            follow_stage();
        end
    end

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    import pipe_pkg::*;
    import dmem_pkg::*;

    localparam int BUF_DEPTH      = 4;
    localparam int MEM_WORDS      = 64;
    localparam int NUM_DIRECTED   = 30;
    localparam int NUM_RANDOM     = 300;
    localparam int TIMEOUT_CYCLES = (NUM_DIRECTED + NUM_RANDOM) * 40 + 500;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           flush_i;
    exe_mem1_pass_t pass_i;
    logic           stall_o;
    excp_pass_t     excp_o;
    logic           resp_valid_o;
    dmem_resp_t     resp_o;
    logic           resp_ready_i = 1'b1;
    logic           bp_mode = 1'b0;
    int             ready_run = 0;
    int             stall_cycles = 0;
    int             tb_errors;
    int             chk_errors;
    int             pending;
    int             resp_count;
    int             prop_fails;

    always #4 clk = ~clk;

    mem_subsys_top #(
        .BUF_DEPTH (BUF_DEPTH),
        .MEM_WORDS (MEM_WORDS)
    ) i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush_i      (flush_i),
        .pass_i       (pass_i),
        .stall_o      (stall_o),
        .excp_o       (excp_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i)
    );

    mem_subsys_checker #(
        .BUF_DEPTH (BUF_DEPTH),
        .MEM_WORDS (MEM_WORDS)
    ) i_checker (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .pass_i        (pass_i),
        .stall_i       (stall_o),
        .excp_i        (excp_o),
        .resp_valid_i  (resp_valid_o),
        .resp_i        (resp_o),
        .resp_ready_i  (resp_ready_i),
        .error_count_o (chk_errors),
        .pending_o     (pending),
        .resp_count_o  (resp_count)
    );

    assign prop_fails = i_dut.i_dmem_req_buffer.i_props.fail_count;

    // long low stretches on resp_ready_i while back-pressure is on
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (ready_run > 0) begin
                ready_run = ready_run - 1;
            end else if (bp_mode) begin
                resp_ready_i = ~resp_ready_i;
                ready_run = resp_ready_i ? int'($urandom_range(3, 0)) :
                                           int'($urandom_range(30, 6));
            end else begin
                resp_ready_i = ($urandom_range(7, 0) != 0);
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n === 1'b1 && stall_o) begin
            stall_cycles++;
        end
    end

    function automatic exe_mem1_pass_t mem_op(input logic st, input logic sg,
                                              input byte_type_e bt, input u32_t addr,
                                              input u32_t data, input reg_idx_t rd);
        exe_mem1_pass_t op;
        op           = '0;
        op.valid     = 1'b1;
        op.is_mem    = 1'b1;
        op.is_store  = st;
        op.is_signed = sg;
        op.byte_type = bt;
        op.addr      = addr;
        op.rkd_data  = data;
        op.rd        = rd;
        return op;
    endfunction

    function automatic exe_mem1_pass_t non_mem_op(input reg_idx_t rd);
        exe_mem1_pass_t op;
        op       = '0;
        op.valid = 1'b1;
        op.rd    = rd;
        return op;
    endfunction

    // mostly aligned accesses inside a 64-byte window, some non-memory ops
    function automatic exe_mem1_pass_t random_op();
        exe_mem1_pass_t op;
        op           = mem_op(1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)),
                              byte_type_e'(2'($urandom_range(2, 0))),
                              32'($urandom_range(63, 0)), $urandom(),
                              5'($urandom_range(31, 0)));
        op.is_mem    = ($urandom_range(9, 0) != 0);
        if ($urandom_range(7, 0) != 0) begin
            if (op.byte_type == HALF_WORD) begin
                op.addr[0] = 1'b0;
            end else if (op.byte_type == WORD) begin
                op.addr[1:0] = 2'b00;
            end
        end
        return op;
    endfunction

    // holds the op on pass_i until the stage takes it
    task automatic issue_op(input exe_mem1_pass_t op);
        logic taken;
        pass_i = op;
        taken  = 1'b0;
        while (!taken) begin
            @(posedge clk);
            taken = !stall_o;
            @(negedge clk);
        end
        pass_i = '0;
    endtask

    task automatic pulse_flush();
        pass_i  = '0;
        flush_i = 1'b1;
        @(negedge clk);
        flush_i = 1'b0;
    endtask

    initial begin
        void'($urandom(80116));
        rst_n     = 1'b0;
        flush_i   = 1'b0;
        pass_i    = '0;
        tb_errors = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        issue_op(mem_op(1'b1, 1'b0, WORD, 32'h10, 32'hdeadbeef, 5'd3));
        issue_op(mem_op(1'b0, 1'b0, WORD, 32'h10, 32'h0, 5'd4));

        // merge byte and half-word stores into one word, then read every lane back
        issue_op(mem_op(1'b1, 1'b0, WORD, 32'h20, 32'h11223344, 5'd1));
        issue_op(mem_op(1'b1, 1'b0, BYTE, 32'h21, 32'h000000a5, 5'd2));
        issue_op(non_mem_op(5'd7));
        issue_op(mem_op(1'b1, 1'b0, HALF_WORD, 32'h22, 32'h00008001, 5'd3));
        for (int i = 0; i < 4; i++) begin
            for (int s = 0; s < 2; s++) begin
                issue_op(mem_op(1'b0, 1'(s), BYTE, 32'h20 + 32'(i), '0, 5'(8 + 2 * i + s)));
            end
        end
        for (int i = 0; i < 2; i++) begin
            issue_op(mem_op(1'b0, 1'b1, HALF_WORD, 32'h20 + 32'(2 * i), '0, 5'(20 + i)));
            issue_op(mem_op(1'b0, 1'b0, HALF_WORD, 32'h20 + 32'(2 * i), '0, 5'(22 + i)));
        end

        // misaligned accesses must leave the memory alone
        issue_op(mem_op(1'b0, 1'b0, HALF_WORD, 32'h31, '0, 5'd5));
        issue_op(mem_op(1'b1, 1'b0, WORD, 32'h22, 32'hffffffff, 5'd6));
        issue_op(mem_op(1'b0, 1'b1, WORD, 32'h23, '0, 5'd7));
        issue_op(mem_op(1'b1, 1'b0, HALF_WORD, 32'h21, 32'h0000ffff, 5'd8));
        issue_op(mem_op(1'b0, 1'b0, WORD, 32'h20, '0, 5'd9));

        // a store killed by flush while it sits in the stage
        issue_op(mem_op(1'b1, 1'b0, WORD, 32'h40, 32'h55aa55aa, 5'd10));
        pulse_flush();
        issue_op(mem_op(1'b0, 1'b0, WORD, 32'h40, '0, 5'd11));

        bp_mode = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_op(random_op());
            if (stall_o && $urandom_range(3, 0) == 0) begin
                pulse_flush();
            end
        end
        bp_mode = 1'b0;

        repeat (4) @(negedge clk);
        while (pending != 0) begin
            @(negedge clk);
        end
        repeat (10) @(negedge clk);
        if (stall_cycles == 0) begin
            $display("stall_o never rose while responses were held back");
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d, assertions %0d, responses %0d",
                 chk_errors, tb_errors, prop_fails, resp_count);
        if (chk_errors + tb_errors + prop_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d operations still unanswered",
                 TIMEOUT_CYCLES, pending);
        $display("test failed");
        $finish;
    end

endmodule

// File: list.f
pipe_pkg.sv
dmem_pkg.sv
mem1_stage.sv
dmem_req_buffer.sv
dmem_unit.sv
mem_subsys_top.sv
mem_subsys_props.sv
mem_subsys_checker.sv
tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
